/* include/vecmat_defs.svh */
`ifndef VECMAT_DEFS_SVH
`define VECMAT_DEFS_SVH

// lanes per column and per softmax vector
`define VM_LANES 32

// Q8.8 fixed point
`define VM_DATA_W 16
`define VM_FRAC_W 8

// column store depth and index width
`define VM_NUM_COLS 8
`define VM_COL_W 3

// store 1 + multiplier 1 + adder tree 2
`define VM_LATENCY 4

`endif

/* hw/vecmat_types_pkg.sv */
`include "vecmat_defs.svh"

package vecmat_types_pkg;

	// one signed Q8.8 value
	typedef logic signed [`VM_DATA_W-1:0] fixed_t;

	// one softmax row, one V column or one row of lane products
	typedef fixed_t [`VM_LANES-1:0] lane_vec_t;

	// full width signed product before the fraction shift
	typedef logic signed [2*`VM_DATA_W-1:0] product_t;

endpackage

/* hw/vecmat_ctrl_pkg.sv */
`include "vecmat_defs.svh"

package vecmat_ctrl_pkg;

	typedef logic [`VM_COL_W-1:0] col_idx_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_DRAIN
	} run_state_t;

endpackage

/* hw/column_store.sv */
`include "vecmat_defs.svh"

module column_store (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        wr_en,
	input  vecmat_ctrl_pkg::col_idx_t   wr_addr,
	input  vecmat_types_pkg::lane_vec_t wr_data,
	input  vecmat_ctrl_pkg::col_idx_t   rd_addr,
	output vecmat_types_pkg::lane_vec_t col_data
);

	vecmat_types_pkg::lane_vec_t mem [`VM_NUM_COLS];

	// no writes land while reset is asserted
	always_ff @(posedge clk) begin
		if (reset && wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read every cycle, the controller decides which reads count
	always_ff @(posedge clk) begin
		col_data <= mem[rd_addr];
	end

endmodule

/* hw/vecmat_mul.sv */
`include "vecmat_defs.svh"

module vecmat_mul (
	input  logic                        clk,
	input  vecmat_types_pkg::lane_vec_t vector,
	input  vecmat_types_pkg::lane_vec_t col_data,
	output vecmat_types_pkg::lane_vec_t products
);

	genvar lane;

	generate
		for (lane = 0; lane < `VM_LANES; lane++) begin : g_lane
			vecmat_types_pkg::product_t prod;
			vecmat_types_pkg::product_t prod_sh;

			// sign extend both operands to full product width
			assign prod = vecmat_types_pkg::product_t'($signed(vector[lane]))
				* vecmat_types_pkg::product_t'($signed(col_data[lane]));

			// drop the extra fraction bits, keep Q8.8
			assign prod_sh = prod >>> `VM_FRAC_W;

			always_ff @(posedge clk) begin
				products[lane] <= prod_sh[`VM_DATA_W-1:0];
			end
		end
	endgenerate

endmodule

/* hw/vecmat_add_tree.sv */
`include "vecmat_defs.svh"

module vecmat_add_tree (
	input  logic                        clk,
	input  vecmat_types_pkg::lane_vec_t products,
	output vecmat_types_pkg::fixed_t    dot_out
);

	vecmat_types_pkg::fixed_t lvl1 [16];
	vecmat_types_pkg::fixed_t lvl2 [8];
	vecmat_types_pkg::fixed_t mid_q [8];
	vecmat_types_pkg::fixed_t lvl3 [4];
	vecmat_types_pkg::fixed_t lvl4 [2];
	vecmat_types_pkg::fixed_t lvl5;

	genvar i;

	// all adds are 16 bit and wrap
	generate
		for (i = 0; i < 16; i++) begin : g_lvl1
			assign lvl1[i] = products[2*i] + products[2*i+1];
		end

		for (i = 0; i < 8; i++) begin : g_lvl2
			assign lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
		end

		for (i = 0; i < 4; i++) begin : g_lvl3
			assign lvl3[i] = mid_q[2*i] + mid_q[2*i+1];
		end

		for (i = 0; i < 2; i++) begin : g_lvl4
			assign lvl4[i] = lvl3[2*i] + lvl3[2*i+1];
		end
	endgenerate

	assign lvl5 = lvl4[0] + lvl4[1];

	// pipeline cut after the second level
	always_ff @(posedge clk) begin
		for (int k = 0; k < 8; k++) begin
			mid_q[k] <= lvl2[k];
		end
	end

	always_ff @(posedge clk) begin
		dot_out <= lvl5;
	end

endmodule

/* hw/col_counter.sv */
`include "vecmat_defs.svh"

module col_counter (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      count_en,
	output vecmat_ctrl_pkg::col_idx_t rd_addr,
	output logic                      rd_strobe,
	output logic                      last_col
);

	localparam vecmat_ctrl_pkg::col_idx_t LAST_ADDR =
		vecmat_ctrl_pkg::col_idx_t'(`VM_NUM_COLS - 1);

	vecmat_ctrl_pkg::col_idx_t addr_q;

	always_ff @(posedge clk) begin
		if (!reset) begin
			addr_q <= '0;
		end else if (count_en) begin
			if (addr_q == LAST_ADDR) begin
				addr_q <= '0;
			end else begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

	// one read per enabled cycle
	assign rd_addr   = addr_q;
	assign rd_strobe = count_en;
	assign last_col  = count_en && (addr_q == LAST_ADDR);

endmodule

/* hw/vecmat_ctrl.sv */
`include "vecmat_defs.svh"

module vecmat_ctrl (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic                      rd_strobe,
	input  logic                      last_col,
	output logic                      count_en,
	output logic                      store_wr_allow,
	output logic                      busy,
	output logic                      result_valid,
	output vecmat_ctrl_pkg::col_idx_t result_index,
	output logic                      done
);

	vecmat_ctrl_pkg::run_state_t state;
	vecmat_ctrl_pkg::run_state_t state_next;

	logic [`VM_LATENCY-1:0] strobe_pipe;
	logic [`VM_LATENCY-1:0] last_pipe;

	always_comb begin
		state_next = state;
		case (state)
			vecmat_ctrl_pkg::ST_IDLE: begin
				if (start) begin
					state_next = vecmat_ctrl_pkg::ST_ISSUE;
				end
			end
			vecmat_ctrl_pkg::ST_ISSUE: begin
				if (last_col) begin
					state_next = vecmat_ctrl_pkg::ST_DRAIN;
				end
			end
			vecmat_ctrl_pkg::ST_DRAIN: begin
				if (done) begin
					state_next = vecmat_ctrl_pkg::ST_IDLE;
				end
			end
			default: begin
				state_next = vecmat_ctrl_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= vecmat_ctrl_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// strobe and last follow the data through store, multiplier and tree
	always_ff @(posedge clk) begin
		if (!reset) begin
			strobe_pipe <= '0;
			last_pipe   <= '0;
		end else begin
			strobe_pipe <= {strobe_pipe[`VM_LATENCY-2:0], rd_strobe};
			last_pipe   <= {last_pipe[`VM_LATENCY-2:0], last_col};
		end
	end

	always_ff @(posedge clk) begin
		if (!reset || done) begin
			result_index <= '0;
		end else if (result_valid) begin
			result_index <= result_index + 1'b1;
		end
	end

	assign count_en       = (state == vecmat_ctrl_pkg::ST_ISSUE);
	assign busy           = (state != vecmat_ctrl_pkg::ST_IDLE);
	assign store_wr_allow = !busy;
	assign result_valid   = strobe_pipe[`VM_LATENCY-1];
	assign done           = last_pipe[`VM_LATENCY-1];

endmodule

/* hw/vecmat_engine.sv */
module vecmat_engine (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  logic                        wr_en,
	input  vecmat_ctrl_pkg::col_idx_t   wr_addr,
	input  vecmat_types_pkg::lane_vec_t wr_data,
	input  vecmat_types_pkg::lane_vec_t vector,
	output vecmat_types_pkg::fixed_t    dot_out,
	output logic                        result_valid,
	output vecmat_ctrl_pkg::col_idx_t   result_index,
	output logic                        done,
	output logic                        busy
);

	logic                        store_wr_allow;
	logic                        store_wr_en;
	logic                        count_en;
	logic                        rd_strobe;
	logic                        last_col;
	vecmat_ctrl_pkg::col_idx_t   rd_addr;
	vecmat_types_pkg::lane_vec_t col_data;
	vecmat_types_pkg::lane_vec_t products;

	// host writes are dropped during a run
	assign store_wr_en = wr_en && store_wr_allow;

	column_store i_column_store (
		.clk      (clk),
		.reset    (reset),
		.wr_en    (store_wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.col_data (col_data)
	);

	col_counter i_col_counter (
		.clk       (clk),
		.reset     (reset),
		.count_en  (count_en),
		.rd_addr   (rd_addr),
		.rd_strobe (rd_strobe),
		.last_col  (last_col)
	);

	vecmat_ctrl i_vecmat_ctrl (
		.clk            (clk),
		.reset          (reset),
		.start          (start),
		.rd_strobe      (rd_strobe),
		.last_col       (last_col),
		.count_en       (count_en),
		.store_wr_allow (store_wr_allow),
		.busy           (busy),
		.result_valid   (result_valid),
		.result_index   (result_index),
		.done           (done)
	);

	vecmat_mul i_vecmat_mul (
		.clk      (clk),
		.vector   (vector),
		.col_data (col_data),
		.products (products)
	);

	vecmat_add_tree i_vecmat_add_tree (
		.clk      (clk),
		.products (products),
		.dot_out  (dot_out)
	);

endmodule

/* bench/vecmat_engine_tb.sv */
`include "vecmat_defs.svh"

module vecmat_engine_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RUN_LAST     = `VM_LATENCY + `VM_NUM_COLS - 1;
	localparam int DONE_TIMEOUT = 100;

	logic                        clk = 1'b0;
	logic                        reset;
	logic                        start;
	logic                        wr_en;
	vecmat_ctrl_pkg::col_idx_t   wr_addr;
	vecmat_types_pkg::lane_vec_t wr_data;
	vecmat_types_pkg::lane_vec_t vector;
	vecmat_types_pkg::fixed_t    dot_out;
	logic                        result_valid;
	vecmat_ctrl_pkg::col_idx_t   result_index;
	logic                        done;
	logic                        busy;

	// reference model of the column store and the run timing
	vecmat_types_pkg::lane_vec_t model_mem [`VM_NUM_COLS];
	int                          since_start;
	logic                        exp_busy;
	logic                        exp_valid;
	logic                        exp_done;
	vecmat_ctrl_pkg::col_idx_t   exp_index;
	vecmat_types_pkg::fixed_t    exp_dot;

	int mismatch_count = 0;
	int failure_count  = 0;

	vecmat_engine i_vecmat_engine (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.vector       (vector),
		.dot_out      (dot_out),
		.result_valid (result_valid),
		.result_index (result_index),
		.done         (done),
		.busy         (busy)
	);

	always #4 clk = ~clk;

	function automatic vecmat_types_pkg::fixed_t golden_dot(
		input vecmat_types_pkg::lane_vec_t vec,
		input vecmat_types_pkg::lane_vec_t col
	);
		vecmat_types_pkg::product_t full;
		vecmat_types_pkg::product_t scaled;
		vecmat_types_pkg::fixed_t   acc;
		acc = '0;
		for (int lane = 0; lane < `VM_LANES; lane++) begin
			full = vecmat_types_pkg::product_t'($signed(vec[lane]))
				* vecmat_types_pkg::product_t'($signed(col[lane]));
			scaled = full >>> `VM_FRAC_W;
			// 16 bit wrapping accumulate
			acc = acc + scaled[`VM_DATA_W-1:0];
		end
		return acc;
	endfunction

	// mostly random lanes with some extreme values mixed in
	function automatic vecmat_types_pkg::lane_vec_t random_lanes();
		vecmat_types_pkg::lane_vec_t v;
		logic [31:0]                 r;
		for (int lane = 0; lane < `VM_LANES; lane++) begin
			r = $urandom;
			case (r[3:0])
				4'd0: v[lane] = 16'h7fff;
				4'd1: v[lane] = 16'h8000;
				4'd2: v[lane] = 16'hffff;
				default: v[lane] = r[31:16];
			endcase
		end
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		mismatch_count++;
		$display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected,
			actual);
	endtask

	task automatic write_column(input vecmat_ctrl_pkg::col_idx_t addr,
		input vecmat_types_pkg::lane_vec_t data);
		@(posedge clk);
		#1;
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
	endtask

	task automatic end_writes();
		@(posedge clk);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic start_run(input vecmat_types_pkg::lane_vec_t vec);
		@(posedge clk);
		#1;
		vector = vec;
		start  = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			failure_count++;
			$display("error at %0t: no done pulse within %0d cycles", $time, DONE_TIMEOUT);
		end
	endtask

	// cycles since an accepted start or -1 when idle
	always @(posedge clk) begin
		if (!reset) begin
			since_start <= -1;
		end else begin
			if (since_start >= 0) begin
				since_start <= (since_start == RUN_LAST) ? -1 : since_start + 1;
			end else if (start) begin
				since_start <= 0;
			end
			if (wr_en && since_start < 0) begin
				model_mem[wr_addr] <= wr_data;
			end
		end
	end

	always_comb begin
		exp_busy  = (since_start >= 0);
		exp_valid = (since_start >= `VM_LATENCY) && (since_start <= RUN_LAST);
		exp_done  = (since_start == RUN_LAST);
		exp_index = vecmat_ctrl_pkg::col_idx_t'(since_start - `VM_LATENCY);
		exp_dot   = golden_dot(vector, model_mem[exp_index]);
	end

	a_busy: assert property (@(posedge clk) disable iff (!reset) busy == exp_busy)
		else report_mismatch("busy", $sampled(exp_busy), $sampled(busy));

	a_valid: assert property (@(posedge clk) disable iff (!reset) result_valid == exp_valid)
		else report_mismatch("result_valid", $sampled(exp_valid), $sampled(result_valid));

	a_done: assert property (@(posedge clk) disable iff (!reset) done == exp_done)
		else report_mismatch("done", $sampled(exp_done), $sampled(done));

	a_index: assert property (@(posedge clk) disable iff (!reset)
		exp_valid |-> result_index == exp_index)
		else report_mismatch("result_index", $sampled(exp_index), $sampled(result_index));

	a_dot: assert property (@(posedge clk) disable iff (!reset)
		exp_valid |-> dot_out == exp_dot)
		else report_mismatch("dot_out", $sampled(exp_dot), $sampled(dot_out));

	initial begin
		void'($urandom(32'he915_c873));
		reset   = 1'b0;
		start   = 1'b0;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		vector  = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b1;
		repeat (5) @(posedge clk);

		for (int c = 0; c < `VM_NUM_COLS; c++) begin
			write_column(vecmat_ctrl_pkg::col_idx_t'(c), random_lanes());
		end
		end_writes();
		start_run(random_lanes());
		// write and restart while busy are both dropped
		write_column(vecmat_ctrl_pkg::col_idx_t'(3), random_lanes());
		end_writes();
		start_run(vector);
		wait_for_done();

		// rewrite even columns only
		// column 3 keeps its first value
		for (int c = 0; c < `VM_NUM_COLS; c += 2) begin
			write_column(vecmat_ctrl_pkg::col_idx_t'(c), random_lanes());
		end
		end_writes();
		start_run(random_lanes());
		wait_for_done();

		// back to back run right after done
		start_run(random_lanes());
		wait_for_done();
		repeat (6) @(posedge clk);

		$display("checks finished: %0d mismatches, %0d other errors", mismatch_count,
			failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* vecmat_engine.f */
+incdir+include
hw/vecmat_types_pkg.sv
hw/vecmat_ctrl_pkg.sv
hw/column_store.sv
hw/vecmat_mul.sv
hw/vecmat_add_tree.sv
hw/col_counter.sv
hw/vecmat_ctrl.sv
hw/vecmat_engine.sv
bench/vecmat_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vecmat_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=vecmat_engine_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module vecmat_engine_tb -Mdir obj_dir -o "$BIN" \
	-f vecmat_engine.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
